//--- regBridge_defs.svh
`ifndef REGBRIDGE_DEFS_SVH
`define REGBRIDGE_DEFS_SVH

// ---------------------------------------------------------------------------
// bridge geometry
// ---------------------------------------------------------------------------

// byte address width on the host port and on the AXI4-Lite bus
`define REGBRIDGE_ADDR_BITS 8

// data width of host port and bus
// strobe width is this over eight
`define REGBRIDGE_DATA_BITS 32

// 32-bit registers in the bank, byte span is four times this
`define REGBRIDGE_REG_COUNT 16

// ---------------------------------------------------------------------------
// buffering
// ---------------------------------------------------------------------------

// default entries per queue
`define REGBRIDGE_QUEUE_DEPTH 4

`endif

//--- regBridgePkg.sv
`default_nettype none

`include "regBridge_defs.svh"

package regBridgePkg;

	// -----------------------------------------------------------------------
	// bus response codes
	// -----------------------------------------------------------------------

	// only OKAY and SLVERR are ever produced by the bank
	typedef enum logic [1:0] {
		respOkay   = 2'd0,
		respSlvErr = 2'd2
	} respT;

	// -----------------------------------------------------------------------
	// queue payloads
	// -----------------------------------------------------------------------

	// host command as it sits in the command queue
	typedef struct packed {
		logic                                write;
		logic [`REGBRIDGE_ADDR_BITS-1:0]     addr;
		logic [`REGBRIDGE_DATA_BITS-1:0]     data;
		logic [`REGBRIDGE_DATA_BITS/8-1:0]   strb;
	} cmdT;

	// response back to the host, data is zero for writes
	typedef struct packed {
		logic                                write;
		logic [`REGBRIDGE_DATA_BITS-1:0]     data;
		respT                                resp;
	} rspT;

endpackage

`default_nettype wire

//--- payloadQueue.sv
`timescale 1ns/1ps
`default_nettype none

`include "regBridge_defs.svh"

module payloadQueue #(
	parameter type payloadT = logic [7:0],
	parameter int depth = `REGBRIDGE_QUEUE_DEPTH
) (
	input wire logic CLK,
	input wire logic arstN,
	input wire logic inValid,
	output logic inReady,
	input wire payloadT inPayload,
	output logic outValid,
	input wire logic outReady,
	output payloadT outPayload
);

	localparam int ptrBits = (depth > 1) ? $clog2(depth) : 1;
	localparam int cntBits = $clog2(depth + 1);

	payloadT store [depth];
	logic [ptrBits-1:0] rdPtr;
	logic [ptrBits-1:0] wrPtr;
	logic [cntBits-1:0] count;
	logic [cntBits-1:0] countNext;
	logic fullQ;
	logic notEmptyQ;
	logic push;
	logic pop;

	// pointer wrap at the last slot, works for any depth
	function automatic logic [ptrBits-1:0] nextPtr(input logic [ptrBits-1:0] ptr);
		if (ptr == ptrBits'(depth - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// a full queue still takes an entry when the head leaves in the same cycle
	assign inReady = !fullQ || outReady;
	assign outValid = notEmptyQ;
	assign outPayload = store[rdPtr];

	assign push = inValid && inReady;
	assign pop = outValid && outReady;

	always_comb begin
		countNext = count;
		if (push && !pop) begin
			countNext = count + 1'b1;
		end else if (pop && !push) begin
			countNext = count - 1'b1;
		end
	end

	// pointers, count and registered status flags
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
			fullQ <= 1'b0;
			notEmptyQ <= 1'b0;
		end else begin
			if (push) begin
				wrPtr <= nextPtr(wrPtr);
			end
			if (pop) begin
				rdPtr <= nextPtr(rdPtr);
			end
			count <= countNext;
			fullQ <= (countNext == cntBits'(depth));
			notEmptyQ <= (countNext != '0);
		end
	end

	// payload storage
	always_ff @(posedge CLK) begin
		if (push) begin
			store[wrPtr] <= inPayload;
		end
	end

	countBound: assert property (@(posedge CLK) disable iff (!arstN)
		count <= cntBits'(depth))
		else $error("payloadQueue count %0d above depth %0d", count, depth);

endmodule

`default_nettype wire

//--- axiLiteMaster.sv
`timescale 1ns/1ps
`default_nettype none

`include "regBridge_defs.svh"

module axiLiteMaster
	import regBridgePkg::*;
(
	input wire logic CLK,
	input wire logic arstN,
	// command side
	input wire logic cmdValid,
	output logic cmdReady,
	input wire cmdT cmd,
	// response side
	output logic rspValid,
	input wire logic rspReady,
	output rspT rsp,
	// write address
	output logic [`REGBRIDGE_ADDR_BITS-1:0] AWADDR,
	output logic AWVALID,
	input wire logic AWREADY,
	// write data
	output logic [`REGBRIDGE_DATA_BITS-1:0] WDATA,
	output logic [`REGBRIDGE_DATA_BITS/8-1:0] WSTRB,
	output logic WVALID,
	input wire logic WREADY,
	// write response
	input wire logic [1:0] BRESP,
	input wire logic BVALID,
	output logic BREADY,
	// read address
	output logic [`REGBRIDGE_ADDR_BITS-1:0] ARADDR,
	output logic ARVALID,
	input wire logic ARREADY,
	// read data
	input wire logic [`REGBRIDGE_DATA_BITS-1:0] RDATA,
	input wire logic [1:0] RRESP,
	input wire logic RVALID,
	output logic RREADY
);

	typedef enum logic [1:0] {
		sIdle,
		sAddr,
		sResp,
		sPush
	} stateT;

	stateT state;
	logic isWrite;
	logic awDone;
	logic wDone;
	logic [`REGBRIDGE_DATA_BITS-1:0] rspDataQ;
	respT rspRespQ;
	logic pop;
	logic awHs;
	logic wHs;
	logic arHs;
	logic bHs;
	logic rHs;
	logic wrAddrDone;

	// ---------------------------------------------------------------------
	// handshakes
	// ---------------------------------------------------------------------

	assign awHs = AWVALID && AWREADY;
	assign wHs = WVALID && WREADY;
	assign arHs = ARVALID && ARREADY;
	assign bHs = BVALID && BREADY;
	assign rHs = RVALID && RREADY;

	// AW and W may finish in either order
	assign wrAddrDone = (awDone || awHs) && (wDone || wHs);

	// next command only when the response queue can take its answer
	// in sPush the current answer leaves in this same cycle
	assign cmdReady = rspReady && (state == sIdle || state == sPush);
	assign pop = cmdValid && cmdReady;

	assign rspValid = (state == sPush);
	assign rsp = '{write: isWrite, data: rspDataQ, resp: rspRespQ};

	// ---------------------------------------------------------------------
	// FSM with registered bus outputs
	// ---------------------------------------------------------------------

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			state <= sIdle;
			isWrite <= 1'b0;
			awDone <= 1'b0;
			wDone <= 1'b0;
			rspDataQ <= '0;
			rspRespQ <= respOkay;
			AWADDR <= '0;
			AWVALID <= 1'b0;
			WDATA <= '0;
			WSTRB <= '0;
			WVALID <= 1'b0;
			BREADY <= 1'b0;
			ARADDR <= '0;
			ARVALID <= 1'b0;
			RREADY <= 1'b0;
		end else begin
			case (state)
				sAddr: begin
					// drop each valid once its channel has moved
					if (awHs) begin
						AWVALID <= 1'b0;
						awDone <= 1'b1;
					end
					if (wHs) begin
						WVALID <= 1'b0;
						wDone <= 1'b1;
					end
					if (arHs) begin
						ARVALID <= 1'b0;
					end
					if (isWrite ? wrAddrDone : arHs) begin
						state <= sResp;
					end
				end
				sResp: begin
					if (isWrite ? bHs : rHs) begin
						rspDataQ <= isWrite ? '0 : RDATA;
						rspRespQ <= respT'(isWrite ? BRESP : RRESP);
						BREADY <= 1'b0;
						RREADY <= 1'b0;
						state <= sPush;
					end
				end
				sPush: begin
					if (rspReady) begin
						state <= sIdle;
					end
				end
				default: begin
				end
			endcase
			// pop overrides the sPush exit, back-to-back commands
			if (pop) begin
				isWrite <= cmd.write;
				awDone <= 1'b0;
				wDone <= 1'b0;
				if (cmd.write) begin
					AWADDR <= cmd.addr;
					WDATA <= cmd.data;
					WSTRB <= cmd.strb;
				end else begin
					ARADDR <= cmd.addr;
				end
				AWVALID <= cmd.write;
				WVALID <= cmd.write;
				BREADY <= cmd.write;
				ARVALID <= !cmd.write;
				RREADY <= !cmd.write;
				state <= sAddr;
			end
		end
	end

	// ---------------------------------------------------------------------
	// bus protocol checks
	// ---------------------------------------------------------------------

	awHold: assert property (@(posedge CLK) disable iff (!arstN)
		AWVALID && !AWREADY |=> AWVALID && $stable(AWADDR))
		else $error("AWVALID or AWADDR changed before AWREADY");

	wHold: assert property (@(posedge CLK) disable iff (!arstN)
		WVALID && !WREADY |=> WVALID && $stable(WDATA) && $stable(WSTRB))
		else $error("WVALID or write data changed before WREADY");

	arHold: assert property (@(posedge CLK) disable iff (!arstN)
		ARVALID && !ARREADY |=> ARVALID && $stable(ARADDR))
		else $error("ARVALID or ARADDR changed before ARREADY");

	// one transaction at a time on the bus
	noMix: assert property (@(posedge CLK) disable iff (!arstN)
		!(ARVALID && (AWVALID || WVALID)))
		else $error("read and write issued together");

endmodule

`default_nettype wire

//--- axiLiteRegBank.sv
`timescale 1ns/1ps
`default_nettype none

`include "regBridge_defs.svh"

module axiLiteRegBank
	import regBridgePkg::*;
(
	input wire logic CLK,
	input wire logic arstN,
	// write address
	input wire logic [`REGBRIDGE_ADDR_BITS-1:0] AWADDR,
	input wire logic AWVALID,
	output logic AWREADY,
	// write data
	input wire logic [`REGBRIDGE_DATA_BITS-1:0] WDATA,
	input wire logic [`REGBRIDGE_DATA_BITS/8-1:0] WSTRB,
	input wire logic WVALID,
	output logic WREADY,
	// write response
	output logic [1:0] BRESP,
	output logic BVALID,
	input wire logic BREADY,
	// read address
	input wire logic [`REGBRIDGE_ADDR_BITS-1:0] ARADDR,
	input wire logic ARVALID,
	output logic ARREADY,
	// read data
	output logic [`REGBRIDGE_DATA_BITS-1:0] RDATA,
	output logic [1:0] RRESP,
	output logic RVALID,
	input wire logic RREADY
);

	localparam int idxBits = $clog2(`REGBRIDGE_REG_COUNT);
	localparam int strbBits = `REGBRIDGE_DATA_BITS / 8;
	// byte span covered by the register file
	localparam int regSpan = `REGBRIDGE_REG_COUNT * 4;

	logic [`REGBRIDGE_DATA_BITS-1:0] regFile [`REGBRIDGE_REG_COUNT];
	logic [idxBits-1:0] wrIdx;
	logic [idxBits-1:0] rdIdx;
	logic wrInRange;
	logic rdInRange;
	logic wrStart;
	logic rdStart;
	logic wrHs;
	logic rdHs;

	// ---------------------------------------------------------------------
	// address decode
	// ---------------------------------------------------------------------

	// word index from bits above the byte lane, lane bits ignored
	assign wrIdx = AWADDR[idxBits+1:2];
	assign rdIdx = ARADDR[idxBits+1:2];
	assign wrInRange = int'(AWADDR) < regSpan;
	assign rdInRange = int'(ARADDR) < regSpan;

	// ready pulses for one cycle, never while a response is still out
	assign wrStart = AWVALID && WVALID && !BVALID && !AWREADY;
	assign rdStart = ARVALID && !RVALID && !ARREADY;

	// AW and W are always taken together
	assign wrHs = AWVALID && AWREADY && WVALID && WREADY;
	assign rdHs = ARVALID && ARREADY;

	// ---------------------------------------------------------------------
	// write path
	// ---------------------------------------------------------------------

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			AWREADY <= 1'b0;
			WREADY <= 1'b0;
			BVALID <= 1'b0;
			BRESP <= '0;
			for (int i = 0; i < `REGBRIDGE_REG_COUNT; i++) begin
				regFile[i] <= '0;
			end
		end else begin
			AWREADY <= wrStart;
			WREADY <= wrStart;
			if (wrHs) begin
				// byte merge under strobe, out of range writes are dropped
				if (wrInRange) begin
					for (int b = 0; b < strbBits; b++) begin
						if (WSTRB[b]) begin
							regFile[wrIdx][8*b +: 8] <= WDATA[8*b +: 8];
						end
					end
				end
				BRESP <= wrInRange ? respOkay : respSlvErr;
				BVALID <= 1'b1;
			end else if (BVALID && BREADY) begin
				BVALID <= 1'b0;
			end
		end
	end

	// ---------------------------------------------------------------------
	// read path
	// ---------------------------------------------------------------------

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			ARREADY <= 1'b0;
			RVALID <= 1'b0;
			RDATA <= '0;
			RRESP <= '0;
		end else begin
			ARREADY <= rdStart;
			if (rdHs) begin
				// decode error reads as zero
				RDATA <= rdInRange ? regFile[rdIdx] : '0;
				RRESP <= rdInRange ? respOkay : respSlvErr;
				RVALID <= 1'b1;
			end else if (RVALID && RREADY) begin
				RVALID <= 1'b0;
			end
		end
	end

	bHold: assert property (@(posedge CLK) disable iff (!arstN)
		BVALID && !BREADY |=> BVALID && $stable(BRESP))
		else $error("BVALID or BRESP changed before BREADY");

	rHold: assert property (@(posedge CLK) disable iff (!arstN)
		RVALID && !RREADY |=> RVALID && $stable(RDATA) && $stable(RRESP))
		else $error("RVALID or read data changed before RREADY");

endmodule

`default_nettype wire

//--- regBridgeTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "regBridge_defs.svh"

module regBridgeTop
	import regBridgePkg::*;
(
	input wire logic CLK,
	input wire logic arstN,
	// host commands
	input wire logic cmdValid,
	output logic cmdReady,
	input wire logic cmdWrite,
	input wire logic [`REGBRIDGE_ADDR_BITS-1:0] cmdAddr,
	input wire logic [`REGBRIDGE_DATA_BITS-1:0] cmdData,
	input wire logic [`REGBRIDGE_DATA_BITS/8-1:0] cmdStrb,
	// host responses
	output logic rspValid,
	input wire logic rspReady,
	output logic rspWrite,
	output logic [`REGBRIDGE_DATA_BITS-1:0] rspData,
	output logic [1:0] rspResp
);

	cmdT cmdIn;
	cmdT cmdHead;
	logic cmdHeadValid;
	logic cmdHeadReady;
	rspT rspIn;
	logic rspInValid;
	logic rspInReady;
	rspT rspOut;

	// AXI4-Lite between master and bank
	logic [`REGBRIDGE_ADDR_BITS-1:0] awAddr;
	logic awValid;
	logic awReady;
	logic [`REGBRIDGE_DATA_BITS-1:0] wData;
	logic [`REGBRIDGE_DATA_BITS/8-1:0] wStrb;
	logic wValid;
	logic wReady;
	logic [1:0] bResp;
	logic bValid;
	logic bReady;
	logic [`REGBRIDGE_ADDR_BITS-1:0] arAddr;
	logic arValid;
	logic arReady;
	logic [`REGBRIDGE_DATA_BITS-1:0] rData;
	logic [1:0] rResp;
	logic rValid;
	logic rReady;

	// pack loose host fields, unpack the response
	assign cmdIn = '{write: cmdWrite, addr: cmdAddr, data: cmdData, strb: cmdStrb};
	assign rspWrite = rspOut.write;
	assign rspData = rspOut.data;
	assign rspResp = rspOut.resp;

	payloadQueue #(
		.payloadT(cmdT),
		.depth(`REGBRIDGE_QUEUE_DEPTH)
	) cmdQueue (
		.CLK(CLK),
		.arstN(arstN),
		.inValid(cmdValid),
		.inReady(cmdReady),
		.inPayload(cmdIn),
		.outValid(cmdHeadValid),
		.outReady(cmdHeadReady),
		.outPayload(cmdHead)
	);

	axiLiteMaster i_axiLiteMaster (
		.CLK(CLK),
		.arstN(arstN),
		.cmdValid(cmdHeadValid),
		.cmdReady(cmdHeadReady),
		.cmd(cmdHead),
		.rspValid(rspInValid),
		.rspReady(rspInReady),
		.rsp(rspIn),
		.AWADDR(awAddr),
		.AWVALID(awValid),
		.AWREADY(awReady),
		.WDATA(wData),
		.WSTRB(wStrb),
		.WVALID(wValid),
		.WREADY(wReady),
		.BRESP(bResp),
		.BVALID(bValid),
		.BREADY(bReady),
		.ARADDR(arAddr),
		.ARVALID(arValid),
		.ARREADY(arReady),
		.RDATA(rData),
		.RRESP(rResp),
		.RVALID(rValid),
		.RREADY(rReady)
	);

	axiLiteRegBank i_axiLiteRegBank (
		.CLK(CLK),
		.arstN(arstN),
		.AWADDR(awAddr),
		.AWVALID(awValid),
		.AWREADY(awReady),
		.WDATA(wData),
		.WSTRB(wStrb),
		.WVALID(wValid),
		.WREADY(wReady),
		.BRESP(bResp),
		.BVALID(bValid),
		.BREADY(bReady),
		.ARADDR(arAddr),
		.ARVALID(arValid),
		.ARREADY(arReady),
		.RDATA(rData),
		.RRESP(rResp),
		.RVALID(rValid),
		.RREADY(rReady)
	);

	// responses wait here in command order
	payloadQueue #(
		.payloadT(rspT),
		.depth(`REGBRIDGE_QUEUE_DEPTH)
	) rspQueue (
		.CLK(CLK),
		.arstN(arstN),
		.inValid(rspInValid),
		.inReady(rspInReady),
		.inPayload(rspIn),
		.outValid(rspValid),
		.outReady(rspReady),
		.outPayload(rspOut)
	);

endmodule

`default_nettype wire

//--- tbRegBridge.sv
`timescale 1ns/1ps
`default_nettype none

`include "regBridge_defs.svh"

module tbRegBridge
	import regBridgePkg::*;
();

	localparam int addrBits = `REGBRIDGE_ADDR_BITS;
	localparam int dataBits = `REGBRIDGE_DATA_BITS;
	localparam int strbBits = `REGBRIDGE_DATA_BITS / 8;
	localparam int regCount = `REGBRIDGE_REG_COUNT;
	// about 600 commands over all tests, 40 cycles allowed for each
	localparam int timeoutCycles = 600 * 40;

	logic CLK;
	logic arstN;
	logic cmdValid;
	logic cmdReady;
	logic cmdWrite;
	logic [addrBits-1:0] cmdAddr;
	logic [dataBits-1:0] cmdData;
	logic [strbBits-1:0] cmdStrb;
	logic rspValid;
	logic rspReady;
	logic rspWrite;
	logic [dataBits-1:0] rspData;
	logic [1:0] rspResp;

	// reference model of the register bank and the answers still owed
	logic [dataBits-1:0] model [regCount];
	rspT expQ [$];
	logic randomReady;
	int monPass;
	int monFail;
	int mainPass;
	int mainFail;
	int cmdCount;
	int rspCount;
	int stallCycles;
	int cycles;

	regBridgeTop i_regBridgeTop (
		.CLK(CLK),
		.arstN(arstN),
		.cmdValid(cmdValid),
		.cmdReady(cmdReady),
		.cmdWrite(cmdWrite),
		.cmdAddr(cmdAddr),
		.cmdData(cmdData),
		.cmdStrb(cmdStrb),
		.rspValid(rspValid),
		.rspReady(rspReady),
		.rspWrite(rspWrite),
		.rspData(rspData),
		.rspResp(rspResp)
	);

	// ------------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------------

	// compare one value, print the mismatch and return 0 on failure
	function automatic bit sameValue(input string name, input logic [31:0] expVal,
			input logic [31:0] gotVal);
		bit ok;
		ok = 1'b1;
		assert (gotVal === expVal)
		else begin
			$display("CHECK FAILED time=%0t signal=%s expected=%0h actual=%0h",
				$time, name, expVal, gotVal);
			ok = 1'b0;
		end
		return ok;
	endfunction

	// apply a command to the model and build the answer the bank owes
	function automatic rspT modelApply(input logic write, input logic [addrBits-1:0] addr,
			input logic [dataBits-1:0] data, input logic [strbBits-1:0] strb);
		rspT exp;
		int idx;
		bit inRange;
		// byte lane bits are ignored, decode error from byte 64 up
		idx = (int'(addr) / 4) % regCount;
		inRange = int'(addr) < regCount * 4;
		exp.write = write;
		exp.data = '0;
		exp.resp = inRange ? respOkay : respSlvErr;
		if (write && inRange) begin
			for (int b = 0; b < strbBits; b++) begin
				if (strb[b]) begin
					model[idx][8*b +: 8] = data[8*b +: 8];
				end
			end
		end else if (!write && inRange) begin
			exp.data = model[idx];
		end
		return exp;
	endfunction

	// hold one command until the DUT takes it
	task automatic sendCmd(input logic write, input logic [addrBits-1:0] addr,
			input logic [dataBits-1:0] data, input logic [strbBits-1:0] strb);
		@(negedge CLK);
		cmdValid = 1'b1;
		cmdWrite = write;
		cmdAddr = addr;
		cmdData = data;
		cmdStrb = strb;
		@(posedge CLK);
		while (!cmdReady) begin
			@(posedge CLK);
		end
	endtask

	// stop issuing and wait until every owed response came back
	task automatic waitDrain();
		@(negedge CLK);
		cmdValid = 1'b0;
		while (expQ.size() != 0) begin
			@(negedge CLK);
		end
	endtask

	task automatic reportTest(input string name, input int failsBefore);
		int fails;
		fails = monFail + mainFail - failsBefore;
		if (fails == 0) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, fails);
		end
	endtask

	// ------------------------------------------------------------------------
	// clock, host ready and timeout
	// ------------------------------------------------------------------------

	initial begin
		CLK = 1'b0;
		forever begin
			#4 CLK = ~CLK;
		end
	end

	// host takes responses always, or 30 percent of cycles under back-pressure
	initial begin
		rspReady = 1'b0;
		forever begin
			@(negedge CLK);
			if (randomReady) begin
				rspReady = ($urandom_range(99, 0) < 30);
			end else begin
				rspReady = 1'b1;
			end
		end
	end

	initial begin
		cycles = 0;
		forever begin
			@(posedge CLK);
			cycles++;
			if (cycles >= timeoutCycles) begin
				$display("timeout: run did not end within %0d cycles", timeoutCycles);
				$display("Simulation finished: FAIL");
				$finish;
			end
		end
	end

	// ------------------------------------------------------------------------
	// monitor, model update on accept and check on response
	// ------------------------------------------------------------------------

	always @(posedge CLK) begin
		rspT exp;
		if (!arstN) begin
			for (int i = 0; i < regCount; i++) begin
				model[i] = '0;
			end
			expQ.delete();
		end else begin
			if (cmdValid && cmdReady) begin
				expQ.push_back(modelApply(cmdWrite, cmdAddr, cmdData, cmdStrb));
				cmdCount++;
			end
			if (cmdValid && !cmdReady) begin
				stallCycles++;
			end
			if (rspValid && rspReady) begin
				rspCount++;
				if (expQ.size() == 0) begin
					$display("time=%0t a response arrived with no command pending", $time);
					monFail++;
				end else begin
					exp = expQ.pop_front();
					if (sameValue("rspWrite", 32'(exp.write), 32'(rspWrite))) monPass++;
					else monFail++;
					if (sameValue("rspData", exp.data, rspData)) monPass++;
					else monFail++;
					if (sameValue("rspResp", 32'(exp.resp), 32'(rspResp))) monPass++;
					else monFail++;
				end
			end
		end
	end

	// ------------------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------------------

	initial begin
		int failsBefore;
		int cmdBefore;
		int rspBefore;
		int gap;
		logic write;
		logic [addrBits-1:0] addr;
		void'($urandom(11331));
		arstN = 1'b0;
		cmdValid = 1'b0;
		cmdWrite = 1'b0;
		cmdAddr = '0;
		cmdData = '0;
		cmdStrb = '0;
		randomReady = 1'b0;
		monPass = 0;
		monFail = 0;
		mainPass = 0;
		mainFail = 0;
		cmdCount = 0;
		rspCount = 0;
		stallCycles = 0;
		repeat (3) @(posedge CLK);
		@(negedge CLK);
		arstN = 1'b1;

		// idle outputs straight out of reset
		failsBefore = monFail + mainFail;
		@(negedge CLK);
		if (sameValue("rspValid", 32'd0, 32'(rspValid))) mainPass++;
		else mainFail++;
		if (sameValue("cmdReady", 32'd1, 32'(cmdReady))) mainPass++;
		else mainFail++;
		reportTest("reset state", failsBefore);

		// full words, then reads at random in-range addresses
		failsBefore = monFail + mainFail;
		repeat (40) begin
			sendCmd(1'b1, addrBits'($urandom_range(63, 0)), dataBits'($urandom), '1);
		end
		repeat (40) begin
			sendCmd(1'b0, addrBits'($urandom_range(63, 0)), '0, '0);
		end
		waitDrain();
		reportTest("full word write and read", failsBefore);

		// each partial write followed by a read of the same word
		failsBefore = monFail + mainFail;
		repeat (30) begin
			addr = addrBits'($urandom_range(63, 0));
			sendCmd(1'b1, addr, dataBits'($urandom), strbBits'($urandom));
			sendCmd(1'b0, addr, '0, '0);
		end
		waitDrain();
		reportTest("partial strobes", failsBefore);

		// decode errors, then a sweep proves no register moved
		failsBefore = monFail + mainFail;
		repeat (10) begin
			sendCmd(1'b1, addrBits'($urandom_range(255, 64)), dataBits'($urandom), '1);
		end
		repeat (10) begin
			sendCmd(1'b0, addrBits'($urandom_range(255, 64)), '0, '0);
		end
		for (int i = 0; i < regCount; i++) begin
			sendCmd(1'b0, addrBits'(i * 4), '0, '0);
		end
		waitDrain();
		reportTest("decode error", failsBefore);

		// mixed traffic with a slow host so both queues fill
		failsBefore = monFail + mainFail;
		cmdBefore = cmdCount;
		rspBefore = rspCount;
		stallCycles = 0;
		randomReady = 1'b1;
		repeat (400) begin
			gap = $urandom_range(2, 0);
			repeat (gap) begin
				@(negedge CLK);
				cmdValid = 1'b0;
			end
			write = 1'($urandom);
			// about one in ten goes past the register span
			if ($urandom_range(9, 0) == 0) begin
				addr = addrBits'($urandom_range(255, 64));
			end else begin
				addr = addrBits'($urandom_range(63, 0));
			end
			sendCmd(write, addr, dataBits'($urandom), strbBits'($urandom));
		end
		waitDrain();
		randomReady = 1'b0;
		if (sameValue("responseCount", 32'(cmdCount - cmdBefore), 32'(rspCount - rspBefore)))
			mainPass++;
		else mainFail++;
		assert (stallCycles > 0) mainPass++;
		else begin
			$display("time=%0t cmdReady never dropped under back-pressure", $time);
			mainFail++;
		end
		reportTest("back-pressure and order", failsBefore);

		$display("summary: %0d checks passed, %0d checks failed",
			monPass + mainPass, monFail + mainFail);
		if (monFail + mainFail == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
+incdir+.
regBridgePkg.sv
payloadQueue.sv
axiLiteMaster.sv
axiLiteRegBank.sv
regBridgeTop.sv
tbRegBridge.sv

//--- run.sh
#!/bin/sh
# Build and run the register bridge testbench with Verilator.
# Exit status is 0 only when the testbench reports its pass message.

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
	echo "verilator not found in PATH"
	exit 1
fi

verilator --binary --timing --assert -f all.f --top-module tbRegBridge -o simRegBridge
status=$?
if [ $status -ne 0 ]; then
	echo "compile failed with status $status"
	exit 1
fi

output=$(./obj_dir/simRegBridge 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation finished: PASS"; then
	exit 0
fi
echo "pass message not found"
exit 1
